// File: tb/axi_bridge_vectors.txt
# op id user addr data strb exp_resp exp_rdata, all but op in hex
# op: W write, R read, SW and SR stall tests with the response ready held low
W  1 0 0000 11223344 f 0 00000000
R  2 1 0000 00000000 0 0 11223344
W  3 2 0004 deadbeef f 0 00000000
W  4 3 0004 000000a5 1 0 00000000
W  5 0 0004 77660000 c 0 00000000
R  6 1 0004 00000000 0 0 7766bea5
W  7 2 0020 cafef00d f 2 00000000
R  8 3 0020 00000000 0 2 00000000
R  9 0 0000 00000000 0 0 11223344
W  a 1 001c 0badf00d 6 0 00000000
R  b 2 001c 00000000 0 0 00adf000
W  c 3 fffc 12345678 f 2 00000000
R  d 0 0100 00000000 0 2 00000000
W  e 1 0008 a5a5a5a5 f 0 00000000
R  f 2 0008 00000000 0 0 a5a5a5a5
SR 1 1 0008 00000000 0 0 a5a5a5a5
SW 2 3 000c 5a5a5a5a f 0 00000000
R  3 0 000c 00000000 0 0 5a5a5a5a

// File: filelist.f
hdl/axi_bridge_pkg.sv
hdl/axi_lite_if.sv
hdl/meta_fifo.sv
hdl/axi_to_axi_lite.sv
hdl/axi_lite_regfile.sv
hdl/axi_bridge_top.sv
tb/axi_bridge_checker.sv
tb/axi_bridge_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module axi_bridge_tb \
		-f filelist.f -o axi_bridge_sim
	./obj_dir/axi_bridge_sim > sim.log 2>&1 || echo "tests failed" >> sim.log
	cat sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/axi_bridge_tb.sv
// Testbench for the AXI4 register bridge, replaying a vector file under random back-pressure

`timescale 1ns/1ps

module axi_bridge_tb import axi_bridge_pkg::*; ();

  localparam int unsigned NumPendingRd = 2;
  localparam int unsigned NumPendingWr = 2;
  localparam int unsigned NumRegs      = 8;
  localparam int Timeout = 200;
  localparam int Window  = 20;
  // The register file holds one response per direction, so with ready held low
  // the smaller of the FIFO depth and that single slot can be accepted
  localparam int RdInFlight = (NumPendingRd < 1) ? NumPendingRd : 1;
  localparam int WrInFlight = (NumPendingWr < 1) ? NumPendingWr : 1;

  logic  clk_i, reset_i;
  id_t   s_aw_id_i, s_ar_id_i, s_b_id_o, s_r_id_o;
  user_t s_aw_user_i, s_ar_user_i, s_b_user_o, s_r_user_o;
  addr_t s_aw_addr_i, s_ar_addr_i;
  prot_t s_aw_prot_i, s_ar_prot_i;
  data_t s_w_data_i, s_r_data_o;
  strb_t s_w_strb_i;
  resp_t s_b_resp_o, s_r_resp_o;
  logic  s_aw_valid_i, s_w_valid_i, s_ar_valid_i, s_b_ready_i, s_r_ready_i;
  logic  s_aw_ready_o, s_w_ready_o, s_ar_ready_o, s_b_valid_o, s_r_valid_o, s_r_last_o;

  // Reference copy of the register array
  data_t       model_q [NumRegs];
  // Expected B as {id, user, resp} and R as {id, user, resp, data}, oldest first
  logic [7:0]  wr_exp_q [$];
  logic [39:0] rd_exp_q [$];
  logic [15:0] lfsr_q;
  logic        hold_b, hold_r;
  int          errors, timeouts;

  axi_bridge_top #(
    .NumPendingRd (NumPendingRd),
    .NumPendingWr (NumPendingWr),
    .NumRegs      (NumRegs)
  ) i_axi_bridge_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic in_range(addr_t a);
    return int'(a[AddrWidth-1:2]) < NumRegs;
  endfunction

  function automatic resp_t resp_for(addr_t a);
    return in_range(a) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  // Out-of-range reads return zero
  function automatic data_t model_read(addr_t a);
    if (in_range(a)) return model_q[int'(a[AddrWidth-1:2])];
    return '0;
  endfunction

  function automatic logic chan_ready(logic is_write);
    return is_write ? (s_aw_ready_o && s_w_ready_o) : s_ar_ready_o;
  endfunction

  task automatic report_mismatch(string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(string what);
    timeouts++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  task automatic drive_req(logic is_write, logic valid, id_t id, user_t user, addr_t addr,
                           data_t data, strb_t strb);
    if (is_write) begin
      s_aw_id_i    = id;
      s_aw_user_i  = user;
      s_aw_addr_i  = addr;
      s_aw_prot_i  = '0;
      s_aw_valid_i = valid;
      s_w_data_i   = data;
      s_w_strb_i   = strb;
      s_w_valid_i  = valid;
    end else begin
      s_ar_id_i    = id;
      s_ar_user_i  = user;
      s_ar_addr_i  = addr;
      s_ar_prot_i  = '0;
      s_ar_valid_i = valid;
    end
  endtask

  // Called once a handshake is certain, so the model follows the DUT's write order
  task automatic record(logic is_write, id_t id, user_t user, addr_t addr, data_t data,
                        strb_t strb);
    if (is_write) begin
      wr_exp_q.push_back({id, user, resp_for(addr)});
      for (int b = 0; b < 4; b++) begin
        if (in_range(addr) && strb[b]) begin
          model_q[int'(addr[AddrWidth-1:2])][8*b +: 8] = data[8*b +: 8];
        end
      end
    end else begin
      rd_exp_q.push_back({id, user, resp_for(addr), model_read(addr)});
    end
  endtask

  // Single request, held until its address handshake
  task automatic send(logic is_write, id_t id, user_t user, addr_t addr, data_t data,
                      strb_t strb);
    int waited;
    waited = 0;
    drive_req(is_write, 1'b1, id, user, addr, data, strb);
    #1;
    while (!chan_ready(is_write) && waited < Timeout) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!chan_ready(is_write)) report_timeout(is_write ? "AW and W ready" : "AR ready");
    else record(is_write, id, user, addr, data, strb);
    @(negedge clk_i);
    drive_req(is_write, 1'b0, id, user, addr, data, strb);
  endtask

  // Sampled one step later than the response monitor so both never look at the queues together
  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk_i);
    #2;
    while ((wr_exp_q.size() != 0 || rd_exp_q.size() != 0) && waited < Timeout) begin
      @(negedge clk_i);
      #2;
      waited++;
    end
    if (wr_exp_q.size() != 0 || rd_exp_q.size() != 0) report_timeout("outstanding responses");
  endtask

  // Keeps requesting with the response ready held low and counts accepted addresses
  task automatic stall_test(logic is_write, id_t id, user_t user, addr_t addr, data_t data,
                            strb_t strb);
    int   taken;
    int   waited;
    logic accepted;
    id_t  cur_id;
    drain();
    if (is_write) hold_b = 1'b1;
    else hold_r = 1'b1;
    taken  = 0;
    cur_id = id;
    @(negedge clk_i);
    drive_req(is_write, 1'b1, cur_id, user, addr, data, strb);
    for (int c = 0; c < Window; c++) begin
      #1;
      accepted = chan_ready(is_write);
      if (accepted) begin
        record(is_write, cur_id, user, addr, data, strb);
        taken++;
      end
      @(negedge clk_i);
      if (accepted) begin
        cur_id = cur_id + id_t'(1);
        drive_req(is_write, 1'b1, cur_id, user, addr, data, strb);
      end
    end
    if (taken != (is_write ? WrInFlight : RdInFlight)) begin
      report_mismatch($sformatf("%s stall accepted %0d requests, expected %0d",
                                is_write ? "write" : "read", taken,
                                is_write ? WrInFlight : RdInFlight));
    end
    #1;
    if (is_write) hold_b = 1'b0;
    else hold_r = 1'b0;
    waited = 0;
    while (!chan_ready(is_write) && waited < Timeout) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!chan_ready(is_write)) report_timeout("address ready after releasing the response");
    else record(is_write, cur_id, user, addr, data, strb);
    @(negedge clk_i);
    drive_req(is_write, 1'b0, cur_id, user, addr, data, strb);
    drain();
    @(negedge clk_i);
  endtask

  // Random response readiness, one LFSR bit per channel and cycle, and response checks
  initial begin : response_monitor
    logic [7:0]  wr_exp;
    logic [39:0] rd_exp;
    forever begin
      @(negedge clk_i);
      lfsr_q      = lfsr_step(lfsr_q);
      s_b_ready_i = ~hold_b & lfsr_q[0];
      lfsr_q      = lfsr_step(lfsr_q);
      s_r_ready_i = ~hold_r & lfsr_q[0];
      #1;
      if (s_b_valid_o && s_b_ready_i) begin
        if (wr_exp_q.size() == 0) begin
          report_mismatch("write response without an outstanding write");
        end else begin
          wr_exp = wr_exp_q.pop_front();
          if ({s_b_id_o, s_b_user_o, s_b_resp_o} !== wr_exp) begin
            report_mismatch($sformatf("B id/user/resp %h, expected %h",
                                      {s_b_id_o, s_b_user_o, s_b_resp_o}, wr_exp));
          end
        end
      end
      if (s_r_valid_o && !s_r_last_o) report_mismatch("R beat without last");
      if (s_r_valid_o && s_r_ready_i) begin
        if (rd_exp_q.size() == 0) begin
          report_mismatch("read response without an outstanding read");
        end else begin
          rd_exp = rd_exp_q.pop_front();
          if ({s_r_id_o, s_r_user_o, s_r_resp_o, s_r_data_o} !== rd_exp) begin
            report_mismatch($sformatf("R id/user/resp/data %h, expected %h",
                                      {s_r_id_o, s_r_user_o, s_r_resp_o, s_r_data_o}, rd_exp));
          end
        end
      end
    end
  end

  initial begin : main
    int    fd;
    int    n;
    string line;
    string op;
    id_t   v_id;
    user_t v_user;
    addr_t v_addr;
    data_t v_data;
    strb_t v_strb;
    resp_t v_resp;
    data_t v_rdata;
    errors   = 0;
    timeouts = 0;
    lfsr_q   = 16'd22734;
    hold_b   = 1'b0;
    hold_r   = 1'b0;
    reset_i  = 1'b1;
    s_b_ready_i = 1'b0;
    s_r_ready_i = 1'b0;
    drive_req(1'b1, 1'b0, '0, '0, '0, '0, '0);
    drive_req(1'b0, 1'b0, '0, '0, '0, '0, '0);
    for (int i = 0; i < NumRegs; i++) model_q[i] = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    fd = $fopen("tb/axi_bridge_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/axi_bridge_vectors.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h", op, v_id, v_user, v_addr, v_data,
                    v_strb, v_resp, v_rdata);
        if (line.getc(0) == "#" || n < 8) continue;
        // The vector's expectations must agree with the address map and the model
        if (v_resp !== resp_for(v_addr)) begin
          report_mismatch($sformatf("vector at %h expects resp %h", v_addr, v_resp));
        end
        if ((op == "R" || op == "SR") && v_rdata !== model_read(v_addr)) begin
          report_mismatch($sformatf("vector at %h expects data %h, model holds %h",
                                    v_addr, v_rdata, model_read(v_addr)));
        end
        case (op)
          "W":  send(1'b1, v_id, v_user, v_addr, v_data, v_strb);
          "R":  send(1'b0, v_id, v_user, v_addr, v_data, v_strb);
          "SW": stall_test(1'b1, v_id, v_user, v_addr, v_data, v_strb);
          "SR": stall_test(1'b0, v_id, v_user, v_addr, v_data, v_strb);
          default: begin
            $display("Unknown operation %s in the vector file", op);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    drain();

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb/axi_bridge_checker.sv
// Bound assertions on the AXI4 handshakes of the adapter and its metadata FIFOs

`timescale 1ns/1ps

module axi_bridge_checker import axi_bridge_pkg::*; #(
  parameter int unsigned NumPendingRd = 2,
  parameter int unsigned NumPendingWr = 2
) (
  input logic  clk_i,
  input logic  reset_i,
  input logic  s_aw_valid_i,
  input logic  s_aw_ready_o,
  input logic  s_ar_valid_i,
  input logic  s_ar_ready_o,
  input id_t   s_b_id_o,
  input user_t s_b_user_o,
  input resp_t s_b_resp_o,
  input logic  s_b_valid_o,
  input logic  s_b_ready_i,
  input id_t   s_r_id_o,
  input user_t s_r_user_o,
  input data_t s_r_data_o,
  input resp_t s_r_resp_o,
  input logic  s_r_valid_o,
  input logic  s_r_ready_i,
  input logic  rd_full_i,
  input logic  rd_empty_i,
  input logic  wr_full_i,
  input logic  wr_empty_i
);

  // Requests accepted on the AXI4 side whose response has not been taken yet
  int rd_open_q;
  int wr_open_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_open_q <= 0;
      wr_open_q <= 0;
    end else begin
      rd_open_q <= rd_open_q + int'(s_ar_valid_i && s_ar_ready_o)
                             - int'(s_r_valid_o && s_r_ready_i);
      wr_open_q <= wr_open_q + int'(s_aw_valid_i && s_aw_ready_o)
                             - int'(s_b_valid_o && s_b_ready_i);
    end
  end

  // A stalled response keeps its valid and payload
  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    s_b_valid_o && !s_b_ready_i |=> s_b_valid_o && $stable({s_b_id_o, s_b_user_o, s_b_resp_o}))
    else $error("B changed while stalled");
  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    s_r_valid_o && !s_r_ready_i |=>
      s_r_valid_o && $stable({s_r_id_o, s_r_user_o, s_r_resp_o, s_r_data_o}))
    else $error("R changed while stalled");

  // A response needs stored metadata, which also rules out FIFO underflow
  a_b_meta: assert property (@(posedge clk_i) disable iff (reset_i) s_b_valid_o |-> !wr_empty_i)
    else $error("B valid with empty write FIFO");
  a_r_meta: assert property (@(posedge clk_i) disable iff (reset_i) s_r_valid_o |-> !rd_empty_i)
    else $error("R valid with empty read FIFO");

  // The full and empty flags that gate the address channels match the open request count
  a_wr_level: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_full_i == (wr_open_q == int'(NumPendingWr)) && wr_empty_i == (wr_open_q == 0))
    else $error("Write FIFO flags disagree with the open write count");
  a_rd_level: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_full_i == (rd_open_q == int'(NumPendingRd)) && rd_empty_i == (rd_open_q == 0))
    else $error("Read FIFO flags disagree with the open read count");

endmodule

bind axi_to_axi_lite axi_bridge_checker #(
  .NumPendingRd (NumPendingRd),
  .NumPendingWr (NumPendingWr)
) i_checker (
  .*,
  .rd_full_i  (rd_full),
  .rd_empty_i (rd_empty),
  .wr_full_i  (wr_full),
  .wr_empty_i (wr_empty)
);

// File: hdl/axi_bridge_top.sv
// Register subsystem top level joining the AXI4 adapter and the AXI4-Lite register file

`timescale 1ns/1ps

module axi_bridge_top import axi_bridge_pkg::*; #(
  parameter int unsigned NumPendingRd = 2,
  parameter int unsigned NumPendingWr = 2,
  parameter int unsigned NumRegs      = 8
) (
  input  logic  clk_i,
  input  logic  reset_i,
  // AXI4 write address channel
  input  id_t   s_aw_id_i,
  input  user_t s_aw_user_i,
  input  addr_t s_aw_addr_i,
  input  prot_t s_aw_prot_i,
  input  logic  s_aw_valid_i,
  output logic  s_aw_ready_o,
  // AXI4 write data channel
  input  data_t s_w_data_i,
  input  strb_t s_w_strb_i,
  input  logic  s_w_valid_i,
  output logic  s_w_ready_o,
  // AXI4 write response channel
  output id_t   s_b_id_o,
  output user_t s_b_user_o,
  output resp_t s_b_resp_o,
  output logic  s_b_valid_o,
  input  logic  s_b_ready_i,
  // AXI4 read address channel
  input  id_t   s_ar_id_i,
  input  user_t s_ar_user_i,
  input  addr_t s_ar_addr_i,
  input  prot_t s_ar_prot_i,
  input  logic  s_ar_valid_i,
  output logic  s_ar_ready_o,
  // AXI4 read data channel
  output id_t   s_r_id_o,
  output user_t s_r_user_o,
  output data_t s_r_data_o,
  output resp_t s_r_resp_o,
  output logic  s_r_last_o,
  output logic  s_r_valid_o,
  input  logic  s_r_ready_i
);

  // Internal AXI4-Lite bus
  axi_lite_if i_lite_bus (.clk_i(clk_i));

  // Strips ID and USER on the way in and restores them on the way out
  axi_to_axi_lite #(
    .NumPendingRd (NumPendingRd),
    .NumPendingWr (NumPendingWr)
  ) i_axi_to_axi_lite (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .s_aw_id_i    (s_aw_id_i),
    .s_aw_user_i  (s_aw_user_i),
    .s_aw_addr_i  (s_aw_addr_i),
    .s_aw_prot_i  (s_aw_prot_i),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_ready_o (s_aw_ready_o),
    .s_w_data_i   (s_w_data_i),
    .s_w_strb_i   (s_w_strb_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_ready_o  (s_w_ready_o),
    .s_b_id_o     (s_b_id_o),
    .s_b_user_o   (s_b_user_o),
    .s_b_resp_o   (s_b_resp_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_user_i  (s_ar_user_i),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_prot_i  (s_ar_prot_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_r_id_o     (s_r_id_o),
    .s_r_user_o   (s_r_user_o),
    .s_r_data_o   (s_r_data_o),
    .s_r_resp_o   (s_r_resp_o),
    .s_r_last_o   (s_r_last_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .lite         (i_lite_bus)
  );

  // Register array behind the Lite bus
  axi_lite_regfile #(
    .NumRegs (NumRegs)
  ) i_axi_lite_regfile (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .lite    (i_lite_bus)
  );

endmodule

// File: hdl/axi_lite_regfile.sv
// AXI4-Lite register file with byte-strobed writes and SLVERR on out-of-range words

`timescale 1ns/1ps

module axi_lite_regfile import axi_bridge_pkg::*; #(
  parameter int unsigned NumRegs = 8
) (
  input  logic    clk_i,
  input  logic    reset_i,
  axi_lite_if.slv lite
);

  // Enough index bits to select any register, at least one
  localparam int unsigned IdxWidth  = (NumRegs > 1) ? $clog2(NumRegs) : 1;
  // Word number taken from a byte address
  localparam int unsigned WordWidth = AddrWidth - 2;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  wr_state_e wr_state_q;
  rd_state_e rd_state_q;

  data_t regs_q [NumRegs];

  // Response payload is held until the master takes it
  resp_t b_resp_q;
  resp_t r_resp_q;
  data_t r_data_q;

  logic [WordWidth-1:0] wr_word;
  logic [WordWidth-1:0] rd_word;
  logic                 wr_in_range;
  logic                 rd_in_range;
  logic                 wr_fire;
  logic                 rd_fire;

  // The word index is the byte address divided by four
  assign wr_word     = lite.aw_addr[AddrWidth-1:2];
  assign rd_word     = lite.ar_addr[AddrWidth-1:2];
  assign wr_in_range = (wr_word < WordWidth'(NumRegs));
  assign rd_in_range = (rd_word < WordWidth'(NumRegs));

  // AW and W are taken in the same cycle, and only with no B outstanding
  assign lite.aw_ready = (wr_state_q == WR_IDLE) & lite.aw_valid & lite.w_valid;
  assign lite.w_ready  = lite.aw_ready;
  assign wr_fire       = lite.aw_ready;

  // One read is held at a time
  assign lite.ar_ready = (rd_state_q == RD_IDLE);
  assign rd_fire       = lite.ar_valid & lite.ar_ready;

  assign lite.b_valid = (wr_state_q == WR_RESP);
  assign lite.b_resp  = b_resp_q;
  assign lite.r_valid = (rd_state_q == RD_RESP);
  assign lite.r_resp  = r_resp_q;
  assign lite.r_data  = r_data_q;

  // State machines and register contents
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= WR_IDLE;
      rd_state_q <= RD_IDLE;
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (wr_fire) begin
        wr_state_q <= WR_RESP;
        // Only strobed bytes of an existing word are touched
        if (wr_in_range) begin
          for (int b = 0; b < StrbWidth; b++) begin
            if (lite.w_strb[b]) begin
              regs_q[wr_word[IdxWidth-1:0]][8*b +: 8] <= lite.w_data[8*b +: 8];
            end
          end
        end
      end else if (lite.b_valid && lite.b_ready) begin
        wr_state_q <= WR_IDLE;
      end

      if (rd_fire) begin
        rd_state_q <= RD_RESP;
      end else if (lite.r_valid && lite.r_ready) begin
        rd_state_q <= RD_IDLE;
      end
    end
  end

  // Response codes and read data are captured at the address handshake
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      // Decode errors return zero data
      r_data_q <= rd_in_range ? regs_q[rd_word[IdxWidth-1:0]] : '0;
    end
  end

endmodule

// File: hdl/axi_to_axi_lite.sv
// AXI4 to AXI4-Lite adapter that stores ID and USER per request and returns them on the response

`timescale 1ns/1ps

module axi_to_axi_lite import axi_bridge_pkg::*; #(
  parameter int unsigned NumPendingRd = 2,
  parameter int unsigned NumPendingWr = 2
) (
  input  logic  clk_i,
  input  logic  reset_i,
  // AXI4 write address channel
  input  id_t   s_aw_id_i,
  input  user_t s_aw_user_i,
  input  addr_t s_aw_addr_i,
  input  prot_t s_aw_prot_i,
  input  logic  s_aw_valid_i,
  output logic  s_aw_ready_o,
  // AXI4 write data channel
  input  data_t s_w_data_i,
  input  strb_t s_w_strb_i,
  input  logic  s_w_valid_i,
  output logic  s_w_ready_o,
  // AXI4 write response channel
  output id_t   s_b_id_o,
  output user_t s_b_user_o,
  output resp_t s_b_resp_o,
  output logic  s_b_valid_o,
  input  logic  s_b_ready_i,
  // AXI4 read address channel
  input  id_t   s_ar_id_i,
  input  user_t s_ar_user_i,
  input  addr_t s_ar_addr_i,
  input  prot_t s_ar_prot_i,
  input  logic  s_ar_valid_i,
  output logic  s_ar_ready_o,
  // AXI4 read data channel
  output id_t   s_r_id_o,
  output user_t s_r_user_o,
  output data_t s_r_data_o,
  output resp_t s_r_resp_o,
  output logic  s_r_last_o,
  output logic  s_r_valid_o,
  input  logic  s_r_ready_i,
  // AXI4-Lite side towards the register file
  axi_lite_if.mst lite
);

  logic rd_full;
  logic rd_empty;
  logic wr_full;
  logic wr_empty;

  // Metadata of the oldest outstanding read and write
  id_t   rd_id;
  user_t rd_user;
  id_t   wr_id;
  user_t wr_user;

  // Reads push on an AR handshake and pop when the single-beat R completes
  meta_fifo #(.Depth(NumPendingRd)) i_fifo_rd (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (s_ar_valid_i & s_ar_ready_o),
    .pop_i   (s_r_valid_o & s_r_ready_i & s_r_last_o),
    .id_i    (s_ar_id_i),
    .user_i  (s_ar_user_i),
    .full_o  (rd_full),
    .empty_o (rd_empty),
    .id_o    (rd_id),
    .user_o  (rd_user)
  );

  // Writes push on an AW handshake and pop on the B handshake
  meta_fifo #(.Depth(NumPendingWr)) i_fifo_wr (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (s_aw_valid_i & s_aw_ready_o),
    .pop_i   (s_b_valid_o & s_b_ready_i),
    .id_i    (s_aw_id_i),
    .user_i  (s_aw_user_i),
    .full_o  (wr_full),
    .empty_o (wr_empty),
    .id_o    (wr_id),
    .user_o  (wr_user)
  );

  // Address channels stall towards both sides while their FIFO is full
  assign lite.aw_addr  = s_aw_addr_i;
  assign lite.aw_prot  = s_aw_prot_i;
  assign lite.aw_valid = s_aw_valid_i & ~wr_full;
  assign s_aw_ready_o  = lite.aw_ready & ~wr_full;

  assign lite.ar_addr  = s_ar_addr_i;
  assign lite.ar_prot  = s_ar_prot_i;
  assign lite.ar_valid = s_ar_valid_i & ~rd_full;
  assign s_ar_ready_o  = lite.ar_ready & ~rd_full;

  // W needs no gating since the register file only takes it together with AW
  assign lite.w_data  = s_w_data_i;
  assign lite.w_strb  = s_w_strb_i;
  assign lite.w_valid = s_w_valid_i;
  assign s_w_ready_o  = lite.w_ready;

  // Responses carry the metadata at the FIFO head
  assign s_b_id_o     = wr_id;
  assign s_b_user_o   = wr_user;
  assign s_b_resp_o   = lite.b_resp;
  assign s_b_valid_o  = lite.b_valid;
  assign lite.b_ready = s_b_ready_i;

  // Every read is a single beat, so last is constant
  assign s_r_id_o     = rd_id;
  assign s_r_user_o   = rd_user;
  assign s_r_data_o   = lite.r_data;
  assign s_r_resp_o   = lite.r_resp;
  assign s_r_last_o   = 1'b1;
  assign s_r_valid_o  = lite.r_valid;
  assign lite.r_ready = s_r_ready_i;

  // A zero-deep FIFO would block its channel forever
  initial begin
    assert (NumPendingRd > 0) else $fatal(1, "NumPendingRd must be at least 1");
    assert (NumPendingWr > 0) else $fatal(1, "NumPendingWr must be at least 1");
  end

endmodule

// File: hdl/meta_fifo.sv
// Synchronous FIFO keeping the ID and USER of each outstanding AXI4 transaction

`timescale 1ns/1ps

module meta_fifo import axi_bridge_pkg::*; #(
  parameter int unsigned Depth = 2
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  push_i,
  input  logic  pop_i,
  input  id_t   id_i,
  input  user_t user_i,
  output logic  full_o,
  output logic  empty_o,
  output id_t   id_o,
  output user_t user_o
);

  // A single entry still needs a one-bit pointer
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  // The counter must be able to hold the value Depth itself
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  id_t   id_q   [Depth];
  user_t user_q [Depth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;

  logic push_en;
  logic pop_en;

  assign full_o  = (cnt_q == CntWidth'(Depth));
  assign empty_o = (cnt_q == '0);

  // Overflowing pushes and underflowing pops are dropped here
  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;

  // The head entry is visible without any delay
  assign id_o   = id_q[rd_ptr_q];
  assign user_o = user_q[rd_ptr_q];

  // Pointers, occupancy and wrap-around
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry storage is written at the tail
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      id_q[wr_ptr_q]   <= id_i;
      user_q[wr_ptr_q] <= user_i;
    end
  end

endmodule

// File: hdl/axi_lite_if.sv
// AXI4-Lite bus bundle between the AXI4 adapter and the register file

`timescale 1ns/1ps

interface axi_lite_if import axi_bridge_pkg::*; (
  input logic clk_i
);

  // Write address channel
  addr_t aw_addr;
  prot_t aw_prot;
  logic  aw_valid;
  logic  aw_ready;

  // Write data channel
  data_t w_data;
  strb_t w_strb;
  logic  w_valid;
  logic  w_ready;

  // Write response channel
  resp_t b_resp;
  logic  b_valid;
  logic  b_ready;

  // Read address channel
  addr_t ar_addr;
  prot_t ar_prot;
  logic  ar_valid;
  logic  ar_ready;

  // Read data channel
  data_t r_data;
  resp_t r_resp;
  logic  r_valid;
  logic  r_ready;

  // The adapter issues requests and accepts responses
  modport mst (
    input  clk_i,
    output aw_addr, aw_prot, aw_valid, input  aw_ready,
    output w_data, w_strb, w_valid,    input  w_ready,
    input  b_resp, b_valid,            output b_ready,
    output ar_addr, ar_prot, ar_valid, input  ar_ready,
    input  r_data, r_resp, r_valid,    output r_ready
  );

  // The register file accepts requests and returns responses
  modport slv (
    input  clk_i,
    input  aw_addr, aw_prot, aw_valid, output aw_ready,
    input  w_data, w_strb, w_valid,    output w_ready,
    output b_resp, b_valid,            input  b_ready,
    input  ar_addr, ar_prot, ar_valid, output ar_ready,
    output r_data, r_resp, r_valid,    input  r_ready
  );

endinterface

// File: hdl/axi_bridge_pkg.sv
// Register bridge package holding the bus widths, vector types and AXI response codes

package axi_bridge_pkg;

  // Both buses use a 16-bit byte address
  localparam int unsigned AddrWidth = 16;

  // One register word is 32 bits wide
  localparam int unsigned DataWidth = 32;

  // One strobe bit per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Sideband widths on the AXI4 side only
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned UserWidth = 2;

  // Protection attribute and response code widths are fixed by AXI
  localparam int unsigned ProtWidth = 3;
  localparam int unsigned RespWidth = 2;

  // Byte address on AXI4 and AXI4-Lite
  typedef logic [AddrWidth-1:0] addr_t;
  // One data word
  typedef logic [DataWidth-1:0] data_t;
  // Byte enables of one word
  typedef logic [StrbWidth-1:0] strb_t;
  // Transaction ID that is reflected on the response
  typedef logic [IdWidth-1:0]   id_t;
  // USER sideband that is reflected on the response
  typedef logic [UserWidth-1:0] user_t;
  // AxPROT attribute
  typedef logic [ProtWidth-1:0] prot_t;
  // BRESP and RRESP code
  typedef logic [RespWidth-1:0] resp_t;

  // Normal access completed
  localparam resp_t RESP_OKAY   = 2'b00;
  // Access reached the slave but was rejected
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage
